// ==== compile.f ====
src/rv_isa_pkg.sv
src/core_pkg.sv
src/decode.sv
src/regs_file.sv
src/reg_clash_fb.sv
src/alu_core.sv
src/flow_ctrl.sv
src/rooth.sv
verification/rooth_assertions.sv
verification/tb_rooth.sv

// ==== verification/tb_rooth.sv ====
// testbench for the rooth core
// program image, data memory model, store checks and bus hold run
`timescale 1ns/1ps

module tb_rooth;

    localparam logic [31:0] poison_addr = 32'h0000_03f0;
    localparam logic [31:0] marker_addr = 32'h0000_03fc;

    logic        clk;
    logic        reset_i;
    logic        bus_hold_i;
    logic        hold_en = 1'b0;
    logic [31:0] pc_o;
    logic [31:0] inst_word;
    logic [31:0] rdata;
    logic [31:0] data_addr_o;
    logic        data_req_o;
    logic        data_wr_en_o;
    logic [31:0] data_wdata_o;

    logic [31:0] prog [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] exp_data [int];
    int          exp_cnt [8];
    int          n_words;
    int          cur_test;
    int          store_cnt = 0;
    int          marks_seen = 0;
    int          errors = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          err_mark;

    rooth rooth_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_hold_i   (bus_hold_i),
        .inst_i       (inst_word),
        .pc_o         (pc_o),
        .data_rdata_i (rdata),
        .data_addr_o  (data_addr_o),
        .data_req_o   (data_req_o),
        .data_wr_en_o (data_wr_en_o),
        .data_wdata_o (data_wdata_o)
    );

    bind rooth rooth_assertions #(.poison_addr(32'h0000_03f0)) rooth_assertions_i (
        .clk          (clk),
        .reset_i      (reset_i),
        .bus_hold_i   (bus_hold_i),
        .pc_i         (pc_o),
        .data_addr_i  (data_addr_o),
        .data_req_i   (data_req_o),
        .data_wr_en_i (data_wr_en_o)
    );

    // both memories answer in the same cycle
    assign inst_word = prog[pc_o[9:2]];
    assign rdata     = data_req_o ? dmem[data_addr_o[9:2]] : 'x;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        bus_hold_i = 1'b0;
        void'($urandom(32'h1ecfecd9));
        forever begin
            @(posedge clk);
            bus_hold_i <= hold_en && ($urandom % 4 == 0);
        end
    end

    // ------------------------------
    // data memory and store checks
    // ------------------------------
    always @(posedge clk) begin
        if (reset_i) begin
            dmem[128] <= 32'h0000_1111;
            dmem[129] <= 32'h0000_2222;
        end else if (data_wr_en_o && data_req_o) begin
            dmem[data_addr_o[9:2]] <= data_wdata_o;
            if (data_addr_o == marker_addr) begin
                assert (store_cnt == exp_cnt[data_wdata_o[2:0]]) else begin
                    $display("FAIL %0t: test %0d made %0d result stores, expected %0d",
                             $time, data_wdata_o, store_cnt, exp_cnt[data_wdata_o[2:0]]);
                    errors <= errors + 1;
                end
                store_cnt  <= 0;
                marks_seen <= marks_seen + 1;
            end else if (exp_data.exists(int'(data_addr_o))) begin
                store_cnt <= store_cnt + 1;
                assert (data_wdata_o == exp_data[int'(data_addr_o)]) else begin
                    $display("FAIL %0t: store to %h wrote %h, expected %h", $time,
                             data_addr_o, data_wdata_o, exp_data[int'(data_addr_o)]);
                    errors <= errors + 1;
                end
            end else begin
                $display("store to unexpected address %h at %0t", data_addr_o, $time);
                errors <= errors + 1;
            end
        end
    end

    // ------------------------------
    // instruction encoders
    // ------------------------------
    function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input int opc, input int imm, input int rs1,
                                           input int f3, input int rd);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(opc)};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        logic [31:0] m;
        m = imm;
        return {m[11:5], 5'(rs2), 5'(rs1), 3'b010, m[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input int f3);
        logic [31:0] m;
        m = imm;
        return {m[12], m[10:5], 5'(rs2), 5'(rs1), 3'(f3), m[4:1], m[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input int imm20, input int rd);
        return {20'(imm20), 5'(rd), 7'b0110111};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        logic [31:0] m;
        m = imm;
        return {m[20], m[10:1], m[11], m[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[n_words] = w;
        n_words++;
    endtask

    task automatic store_result(input int rs, input int addr, input logic [31:0] val);
        emit(s_type(addr, rs, 0));
        exp_data[addr] = val;
        exp_cnt[cur_test]++;
    endtask

    task automatic poison_pair();
        emit(s_type(poison_addr, 12, 0));
        emit(s_type(poison_addr, 12, 0));
    endtask

    // x4 carries the test id to the marker word
    task automatic end_test(input int id);
        emit(i_type('h13, id, 0, 0, 4));
        emit(s_type(marker_addr, 4, 0));
        cur_test = id + 1;
    endtask

    task automatic build_program();
        int jal_pc;
        n_words  = 0;
        cur_test = 2;
        // alu ops on x1 = -20, x2 = 7
        emit(i_type('h13, -20, 0, 0, 1));
        emit(i_type('h13, 7, 0, 0, 2));
        store_result(1, 'h14c, 32'hffff_ffec);
        emit(r_type('h00, 2, 1, 0, 3));
        store_result(3, 'h100, 32'hffff_fff3);
        emit(r_type('h20, 2, 1, 0, 3));
        store_result(3, 'h104, 32'hffff_ffe5);
        emit(r_type('h00, 2, 1, 7, 3));
        store_result(3, 'h108, 32'h0000_0004);
        emit(r_type('h00, 2, 1, 6, 3));
        store_result(3, 'h10c, 32'hffff_ffef);
        emit(r_type('h00, 2, 1, 4, 3));
        store_result(3, 'h110, 32'hffff_ffeb);
        emit(r_type('h00, 2, 1, 2, 3));
        store_result(3, 'h114, 32'h0000_0001);
        emit(r_type('h00, 2, 1, 3, 3));
        store_result(3, 'h118, 32'h0000_0000);
        emit(r_type('h00, 2, 2, 1, 3));
        store_result(3, 'h11c, 32'h0000_0380);
        emit(r_type('h00, 2, 1, 5, 3));
        store_result(3, 'h120, 32'h01ff_ffff);
        emit(r_type('h20, 2, 1, 5, 3));
        store_result(3, 'h124, 32'hffff_ffff);
        emit(i_type('h13, 'h0f0, 1, 4, 3));
        store_result(3, 'h128, 32'hffff_ff1c);
        emit(i_type('h13, -30, 1, 2, 3));
        store_result(3, 'h12c, 32'h0000_0000);
        emit(i_type('h13, -1, 2, 3, 3));
        store_result(3, 'h130, 32'h0000_0001);
        emit(i_type('h13, 'h7ff, 1, 7, 3));
        store_result(3, 'h134, 32'h0000_07ec);
        emit(i_type('h13, 'h400, 2, 6, 3));
        store_result(3, 'h138, 32'h0000_0407);
        emit(i_type('h13, 28, 2, 1, 3));
        store_result(3, 'h13c, 32'h7000_0000);
        emit(i_type('h13, 28, 1, 5, 3));
        store_result(3, 'h140, 32'h0000_000f);
        // srai, bit 30 set in the immediate
        emit(i_type('h13, 'h402, 1, 5, 3));
        store_result(3, 'h144, 32'hffff_fffb);
        emit(u_type('habcde, 3));
        store_result(3, 'h148, 32'habcd_e000);
        end_test(2);
        // loads and back-to-back dependencies
        emit(i_type('h03, 'h200, 0, 2, 5));
        emit(r_type('h00, 5, 5, 0, 6));
        store_result(6, 'h180, 32'h0000_2222);
        emit(i_type('h03, 'h204, 0, 2, 7));
        emit(r_type('h00, 5, 7, 0, 8));
        emit(r_type('h00, 6, 8, 0, 9));
        emit(r_type('h00, 9, 9, 0, 9));
        store_result(8, 'h184, 32'h0000_3333);
        store_result(9, 'h188, 32'h0000_aaaa);
        emit(i_type('h13, 5, 0, 0, 10));
        emit(i_type('h13, 6, 10, 0, 10));
        emit(i_type('h13, -1, 10, 0, 10));
        store_result(10, 'h18c, 32'h0000_000a);
        store_result(9, 'h190, 32'h0000_aaaa);
        emit(i_type('h03, 'h190, 0, 2, 11));
        emit(r_type('h00, 8, 11, 0, 11));
        store_result(11, 'h194, 32'h0000_dddd);
        end_test(3);
        // taken beq, taken bne, not-taken beq, jal
        emit(i_type('h13, 3, 0, 0, 12));
        emit(i_type('h13, 3, 0, 0, 13));
        emit(b_type(12, 12, 13, 0));
        poison_pair();
        emit(i_type('h13, 'h55, 0, 0, 14));
        store_result(14, 'h1a0, 32'h0000_0055);
        emit(b_type(12, 12, 14, 1));
        poison_pair();
        emit(b_type(8, 12, 14, 0));
        store_result(13, 'h1a4, 32'h0000_0003);
        jal_pc = n_words * 4;
        emit(j_type(12, 15));
        poison_pair();
        store_result(15, 'h1a8, jal_pc + 4);
        end_test(4);
        // park here, with two nops for the wrong-path fetches
        emit(j_type(0, 0));
        emit(32'h0000_0013);
        emit(32'h0000_0013);
    endtask

    // ------------------------------
    // sequencing
    // ------------------------------
    function automatic int total_errors();
        return errors + rooth_i.rooth_assertions_i.fail_cnt;
    endfunction

    task automatic apply_reset();
        reset_i <= 1'b1;
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
    endtask

    task automatic wait_marks(input int target, input int limit);
        int n;
        n = 0;
        while (marks_seen < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (marks_seen < target) begin
            $display("timeout: end marker %0d was never stored", target);
            $display("SIMULATION FAILED");
            $finish;
        end
    endtask

    task automatic report(input int id, input string name, input int mark);
        if (total_errors() == mark) begin
            $display("test %0d %s: ok", id, name);
            n_pass++;
        end else begin
            $display("test %0d %s: %0d errors", id, name, total_errors() - mark);
            n_fail++;
        end
    endtask

    initial begin
        reset_i = 1'b1;
        build_program();
        err_mark = total_errors();
        apply_reset();
        // the reset checks cover the first cycle after release
        repeat (2) @(posedge clk);
        report(1, "reset state", err_mark);
        err_mark = total_errors();
        wait_marks(1, 1000);
        report(2, "alu operations", err_mark);
        err_mark = total_errors();
        wait_marks(2, 1000);
        report(3, "forwarding and loads", err_mark);
        err_mark = total_errors();
        wait_marks(3, 1000);
        report(4, "branches and jal", err_mark);
        // second pass of the whole program under random hold
        err_mark = total_errors();
        apply_reset();
        hold_en <= 1'b1;
        wait_marks(6, 4000);
        hold_en <= 1'b0;
        report(5, "bus hold", err_mark);
        $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
        if (n_fail == 0 && total_errors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/rooth_assertions.sv ====
// checks bound into the rooth core
// reset state, poison address and bus hold behaviour
`timescale 1ns/1ps

module rooth_assertions #(
    parameter logic [31:0] poison_addr = 32'h0000_03f0
) (
    input logic                       clk,
    input logic                       reset_i,
    input logic                       bus_hold_i,
    input logic [core_pkg::xlen-1:0]  pc_i,
    input logic [core_pkg::xlen-1:0]  data_addr_i,
    input logic                       data_req_i,
    input logic                       data_wr_en_i
);
    import core_pkg::*;

    int fail_cnt = 0;

    // every reset edge leaves pc at reset_pc and the data bus idle
    reset_state: assert property (@(posedge clk)
        reset_i |=> pc_i == reset_pc && !data_req_i && !data_wr_en_i)
        else begin
            fail_cnt++;
            $error("pc or data bus not in reset state after a reset edge");
        end

    // flushed stores must never reach memory
    no_poison_write: assert property (@(posedge clk) disable iff (reset_i)
        data_wr_en_i |-> data_addr_i != poison_addr)
        else begin
            fail_cnt++;
            $error("write reached the poison address");
        end

    hold_freeze: assert property (@(posedge clk) disable iff (reset_i)
        bus_hold_i |=> $stable(pc_i) && $stable(data_addr_i))
        else begin
            fail_cnt++;
            $error("pc or data address moved during bus hold");
        end

    hold_no_write: assert property (@(posedge clk) disable iff (reset_i)
        bus_hold_i |-> !data_wr_en_i)
        else begin
            fail_cnt++;
            $error("data write enable high during bus hold");
        end

endmodule

// ==== src/rooth.sv ====
// rooth five-stage RV32I core
// pc, stage registers, hold and flush, data memory steering
`timescale 1ns/1ps

module rooth (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       bus_hold_i,
    input  logic [core_pkg::xlen-1:0]  inst_i,
    output logic [core_pkg::xlen-1:0]  pc_o,
    input  logic [core_pkg::xlen-1:0]  data_rdata_i,
    output logic [core_pkg::xlen-1:0]  data_addr_o,
    output logic                       data_req_o,
    output logic                       data_wr_en_o,
    output logic [core_pkg::xlen-1:0]  data_wdata_o
);
    import core_pkg::*;
    import rv_isa_pkg::*;

    // decode stage
    inst_u                 de_inst;
    inst_u                 de_inst_v;
    logic [xlen-1:0]       de_pc;
    ctrl_t                 de_ctrl;
    logic [xlen-1:0]       de_imm;
    logic [reg_addr_w-1:0] de_rs1;
    logic [reg_addr_w-1:0] de_rs2;
    logic [reg_addr_w-1:0] de_rd;

    // execute stage
    de_ex_t                ex_q;
    logic [xlen-1:0]       rf_rs1_data;
    logic [xlen-1:0]       rf_rs2_data;
    logic [xlen-1:0]       ex_rs1_data;
    logic [xlen-1:0]       ex_rs2_data;
    logic [xlen-1:0]       ex_alu_res;
    logic                  ex_equal;
    logic                  ex_taken;
    logic [xlen-1:0]       ex_next_pc;

    // access and write-back
    ex_as_t                as_q;
    logic [xlen-1:0]       as_wr_data;
    as_wb_t                wb_q;

    // ------------------------------
    // fetch
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= reset_pc;
        end else if (!bus_hold_i) begin
            pc_o <= ex_taken ? ex_next_pc : pc_o + xlen'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_inst <= nop_inst;
            de_pc   <= reset_pc;
        end else if (!bus_hold_i) begin
            de_inst <= ex_taken ? nop_inst : inst_i;
            de_pc   <= pc_o;
        end
    end

    // ------------------------------
    // decode
    // ------------------------------
    // a taken branch kills the instruction sitting in decode
    assign de_inst_v = ex_taken ? nop_inst : de_inst;

    decode u_decode_0 (
        .inst_i (de_inst_v),
        .ctrl_o (de_ctrl),
        .imm_o  (de_imm),
        .rs1_o  (de_rs1),
        .rs2_o  (de_rs2),
        .rd_o   (de_rd)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_q <= '0;
        end else if (!bus_hold_i) begin
            ex_q <= '{ctrl: de_ctrl, pc: de_pc, imm: de_imm,
                      rs1: de_rs1, rs2: de_rs2, rd: de_rd};
        end
    end

    // ------------------------------
    // execute
    // ------------------------------
    regs_file u_regs_file_0 (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_en_i    (wb_q.reg_wr_en & ~bus_hold_i),
        .wr_addr_i  (wb_q.rd),
        .wr_data_i  (wb_q.wr_data),
        .rd1_addr_i (ex_q.rs1),
        .rd2_addr_i (ex_q.rs2),
        .rd1_data_o (rf_rs1_data),
        .rd2_data_o (rf_rs2_data)
    );

    reg_clash_fb u_reg_clash_fb_0 (
        .as_wr_en_i    (as_q.reg_wr_en),
        .as_rd_i       (as_q.rd),
        .as_data_i     (as_wr_data),
        .wb_wr_en_i    (wb_q.reg_wr_en),
        .wb_rd_i       (wb_q.rd),
        .wb_data_i     (wb_q.wr_data),
        .rs1_i         (ex_q.rs1),
        .rs2_i         (ex_q.rs2),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .rs1_data_o    (ex_rs1_data),
        .rs2_data_o    (ex_rs2_data)
    );

    alu_core u_alu_core_0 (
        .ctrl_i     (ex_q.ctrl),
        .pc_i       (ex_q.pc),
        .imm_i      (ex_q.imm),
        .rs1_data_i (ex_rs1_data),
        .rs2_data_i (ex_rs2_data),
        .alu_res_o  (ex_alu_res),
        .equal_o    (ex_equal)
    );

    flow_ctrl u_flow_ctrl_0 (
        .ctrl_i    (ex_q.ctrl),
        .pc_i      (ex_q.pc),
        .imm_i     (ex_q.imm),
        .equal_i   (ex_equal),
        .taken_o   (ex_taken),
        .next_pc_o (ex_next_pc)
    );

    always_ff @(posedge clk) begin
        if (reset_i) begin
            as_q <= '0;
        end else if (!bus_hold_i) begin
            as_q <= '{reg_wr_en: ex_q.ctrl.reg_wr_en, mem_rd: ex_q.ctrl.mem_rd,
                      mem_wr: ex_q.ctrl.mem_wr, rd: ex_q.rd,
                      alu_res: ex_alu_res, store_data: ex_rs2_data};
        end
    end

    // ------------------------------
    // access
    // ------------------------------
    assign data_addr_o  = as_q.alu_res;
    assign data_wdata_o = as_q.store_data;
    assign data_req_o   = as_q.mem_rd | as_q.mem_wr;
    assign data_wr_en_o = as_q.mem_wr & ~bus_hold_i;

    // load data arrives in the same cycle
    assign as_wr_data = as_q.mem_rd ? data_rdata_i : as_q.alu_res;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_q <= '0;
        end else if (!bus_hold_i) begin
            wb_q <= '{reg_wr_en: as_q.reg_wr_en, rd: as_q.rd, wr_data: as_wr_data};
        end
    end

endmodule

// ==== src/flow_ctrl.sv ====
// branch and jump resolution in execute
`timescale 1ns/1ps

module flow_ctrl (
    input  core_pkg::ctrl_t            ctrl_i,
    input  logic [core_pkg::xlen-1:0]  pc_i,
    input  logic [core_pkg::xlen-1:0]  imm_i,
    input  logic                       equal_i,
    output logic                       taken_o,
    output logic [core_pkg::xlen-1:0]  next_pc_o
);
    import core_pkg::*;

    logic            cond_met;
    logic [xlen-1:0] target;

    // beq on equal, bne on not equal
    assign cond_met = equal_i ^ ctrl_i.branch_ne;

    assign taken_o = ctrl_i.jump | (ctrl_i.branch & cond_met);

    // both beq/bne and jal are pc relative
    assign target    = pc_i + imm_i;
    assign next_pc_o = target;

endmodule

// ==== src/alu_core.sv ====
// execute stage ALU
// operand select, arithmetic and logic ops, equality for branches
`timescale 1ns/1ps

module alu_core (
    input  core_pkg::ctrl_t            ctrl_i,
    input  logic [core_pkg::xlen-1:0]  pc_i,
    input  logic [core_pkg::xlen-1:0]  imm_i,
    input  logic [core_pkg::xlen-1:0]  rs1_data_i,
    input  logic [core_pkg::xlen-1:0]  rs2_data_i,
    output logic [core_pkg::xlen-1:0]  alu_res_o,
    output logic                       equal_o
);
    import core_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;

    assign op_a = (ctrl_i.src_a == src_a_pc) ? pc_i : rs1_data_i;

    // jal links pc + 4
    assign op_b = ctrl_i.jump                 ? xlen'(4) :
                  (ctrl_i.src_b == src_b_imm) ? imm_i    : rs2_data_i;

    always_comb begin
        case (ctrl_i.alu_op)
            alu_add:    alu_res_o = op_a + op_b;
            alu_sub:    alu_res_o = op_a - op_b;
            alu_and:    alu_res_o = op_a & op_b;
            alu_or:     alu_res_o = op_a | op_b;
            alu_xor:    alu_res_o = op_a ^ op_b;
            alu_slt:    alu_res_o = xlen'($signed(op_a) < $signed(op_b));
            alu_sltu:   alu_res_o = xlen'(op_a < op_b);
            alu_sll:    alu_res_o = op_a << op_b[4:0];
            alu_srl:    alu_res_o = op_a >> op_b[4:0];
            alu_sra:    alu_res_o = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_pass_b: alu_res_o = op_b;
            default:    alu_res_o = op_a + op_b;
        endcase
    end

    // forwarded register values, not the muxed operands
    assign equal_o = rs1_data_i == rs2_data_i;

endmodule

// ==== src/reg_clash_fb.sv ====
// operand forwarding into execute
// access stage wins over write-back
`timescale 1ns/1ps

module reg_clash_fb (
    input  logic                            as_wr_en_i,
    input  logic [core_pkg::reg_addr_w-1:0] as_rd_i,
    input  logic [core_pkg::xlen-1:0]       as_data_i,
    input  logic                            wb_wr_en_i,
    input  logic [core_pkg::reg_addr_w-1:0] wb_rd_i,
    input  logic [core_pkg::xlen-1:0]       wb_data_i,
    input  logic [core_pkg::reg_addr_w-1:0] rs1_i,
    input  logic [core_pkg::reg_addr_w-1:0] rs2_i,
    input  logic [core_pkg::xlen-1:0]       rf_rs1_data_i,
    input  logic [core_pkg::xlen-1:0]       rf_rs2_data_i,
    output logic [core_pkg::xlen-1:0]       rs1_data_o,
    output logic [core_pkg::xlen-1:0]       rs2_data_o
);
    import core_pkg::*;

    function automatic logic [xlen-1:0] pick(input logic [reg_addr_w-1:0] rs,
                                             input logic [xlen-1:0]       rf_data);
        if (rs == '0) begin
            return rf_data;
        end
        if (as_wr_en_i && as_rd_i == rs) begin
            return as_data_i;
        end
        if (wb_wr_en_i && wb_rd_i == rs) begin
            return wb_data_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs1_data_o = pick(rs1_i, rf_rs1_data_i);
        rs2_data_o = pick(rs2_i, rf_rs2_data_i);
    end

endmodule

// ==== src/regs_file.sv ====
// integer register file, x0 reads as zero
`timescale 1ns/1ps

module regs_file (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            wr_en_i,
    input  logic [core_pkg::reg_addr_w-1:0] wr_addr_i,
    input  logic [core_pkg::xlen-1:0]       wr_data_i,
    input  logic [core_pkg::reg_addr_w-1:0] rd1_addr_i,
    input  logic [core_pkg::reg_addr_w-1:0] rd2_addr_i,
    output logic [core_pkg::xlen-1:0]       rd1_data_o,
    output logic [core_pkg::xlen-1:0]       rd2_data_o
);
    import core_pkg::*;

    // x1..x31 only
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rd1_data_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];

endmodule

// ==== src/decode.sv ====
// instruction decoder
// control fields, register addresses and the sign-extended immediate
`timescale 1ns/1ps

module decode (
    input  rv_isa_pkg::inst_u                inst_i,
    output core_pkg::ctrl_t                  ctrl_o,
    output logic [core_pkg::xlen-1:0]        imm_o,
    output logic [core_pkg::reg_addr_w-1:0]  rs1_o,
    output logic [core_pkg::reg_addr_w-1:0]  rs2_o,
    output logic [core_pkg::reg_addr_w-1:0]  rd_o
);
    import core_pkg::*;
    import rv_isa_pkg::*;

    logic [31:0] inst_w;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            f3_add:  return alt ? alu_sub : alu_add;
            f3_sll:  return alu_sll;
            f3_slt:  return alu_slt;
            f3_sltu: return alu_sltu;
            f3_xor:  return alu_xor;
            f3_sr:   return alt ? alu_sra : alu_srl;
            f3_or:   return alu_or;
            f3_and:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign inst_w = inst_i;

    assign rs1_o = inst_i.r.rs1;
    assign rs2_o = inst_i.r.rs2;
    assign rd_o  = inst_i.r.rd;

    always_comb begin
        // unknown opcodes fall through as a nop
        ctrl_o.alu_op    = alu_add;
        ctrl_o.src_a     = src_a_rs1;
        ctrl_o.src_b     = src_b_rs2;
        ctrl_o.reg_wr_en = 1'b0;
        ctrl_o.mem_rd    = 1'b0;
        ctrl_o.mem_wr    = 1'b0;
        ctrl_o.branch    = 1'b0;
        ctrl_o.branch_ne = 1'b0;
        ctrl_o.jump      = 1'b0;
        imm_o            = '0;
        case (inst_i.r.opcode)
            op_reg: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.alu_op    = alu_sel(inst_i.r.funct3, inst_w[funct7_alt_bit]);
            end
            op_imm: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.src_b     = src_b_imm;
                // addi has no sub form, only srai reads the alt bit
                ctrl_o.alu_op    = alu_sel(inst_i.i.funct3,
                                           inst_w[funct7_alt_bit] && inst_i.i.funct3 == f3_sr);
                imm_o            = {{20{inst_i.i.imm12[11]}}, inst_i.i.imm12};
            end
            op_lui: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.src_b     = src_b_imm;
                ctrl_o.alu_op    = alu_pass_b;
                imm_o            = {inst_i.r.funct7, inst_i.r.rs2, inst_i.r.rs1,
                                    inst_i.r.funct3, 12'b0};
            end
            op_load: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.mem_rd    = 1'b1;
                ctrl_o.src_b     = src_b_imm;
                imm_o            = {{20{inst_i.i.imm12[11]}}, inst_i.i.imm12};
            end
            op_store: begin
                ctrl_o.mem_wr    = 1'b1;
                ctrl_o.src_b     = src_b_imm;
                imm_o            = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
            end
            op_branch: begin
                ctrl_o.branch    = inst_i.s.funct3 == f3_beq || inst_i.s.funct3 == f3_bne;
                ctrl_o.branch_ne = inst_i.s.funct3 == f3_bne;
                imm_o            = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_lo[0],
                                    inst_i.s.imm_hi[5:0], inst_i.s.imm_lo[4:1], 1'b0};
            end
            op_jal: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.jump      = 1'b1;
                ctrl_o.src_a     = src_a_pc;
                imm_o            = {{12{inst_i.r.funct7[6]}}, inst_i.r.rs1, inst_i.r.funct3,
                                    inst_i.r.rs2[0], inst_i.r.funct7[5:0],
                                    inst_i.r.rs2[4:1], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

// ==== src/core_pkg.sv ====
// rooth core types
// widths, alu op codes and the pipeline stage records
package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = '0;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_pass_b
    } alu_op_e;

    typedef enum logic {
        src_a_rs1,
        src_a_pc
    } src_a_e;

    typedef enum logic {
        src_b_rs2,
        src_b_imm
    } src_b_e;

    typedef struct packed {
        alu_op_e alu_op;
        src_a_e  src_a;
        src_b_e  src_b;
        logic    reg_wr_en;
        logic    mem_rd;
        logic    mem_wr;
        logic    branch;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    // ------------------------------
    // stage registers
    // ------------------------------
    typedef struct packed {
        ctrl_t                 ctrl;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
    } de_ex_t;

    typedef struct packed {
        logic                  reg_wr_en;
        logic                  mem_rd;
        logic                  mem_wr;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       alu_res;
        logic [xlen-1:0]       store_data;
    } ex_as_t;

    typedef struct packed {
        logic                  reg_wr_en;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       wr_data;
    } as_wb_t;

endpackage

// ==== src/rv_isa_pkg.sv ====
// RV32I instruction set encodings
// opcodes, funct3 codes and the instruction word layouts
package rv_isa_pkg;

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } op_e;

    // funct3 for alu ops
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // funct3 for branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    // sub and sra select
    localparam int funct7_alt_bit = 30;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // one word, three layouts; b, u and j come out of these too
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } inst_u;

    // addi x0, x0, 0
    localparam logic [31:0] nop_inst = 32'h0000_0013;

endpackage
